// ==== logic/ex_wb_defines.svh ====
`ifndef EX_WB_DEFINES_SVH
`define EX_WB_DEFINES_SVH

// ####################
// Datapath widths
// ####################

`define WORD_W          32
`define REG_AW          5

// ####################
// Memory-mapped window
// ####################

// Bit 0 is tx ready, bit 1 is rx valid
`define MMIO_UART_STAT  32'h8000_0000
// Load pops the rx byte, store sends a tx byte
`define MMIO_UART_DATA  32'h8000_0004
`define MMIO_CYCLE      32'h8000_0010
`define MMIO_INSTRET    32'h8000_0014
// Store here clears both counters
`define MMIO_CNT_RST    32'h8000_0018

`endif

// ==== logic/ex_wb_pkg.sv ====
`include "ex_wb_defines.svh"

package ex_wb_pkg;

    // ####################
    // Enumerations
    // ####################

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2,
        WB_MMIO = 2'd3
    } wb_sel_e;

    // Encoded like funct3 of the RV32I loads
    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_H  = 3'd1,
        LD_W  = 3'd2,
        LD_BU = 3'd4,
        LD_HU = 3'd5
    } load_kind_e;

    // ####################
    // Stage records
    // ####################

    typedef struct packed {
        logic [`WORD_W-1:0] alu_result;   // Doubles as the memory address
        logic [`REG_AW-1:0] rd;
        wb_sel_e            wb_sel;
        load_kind_e         load_kind;
        logic               wb_en;
        logic               store;
        logic [7:0]         store_data;   // Low byte of rs2
        logic [`WORD_W-1:0] pc_plus;
    } ex_wb_t;

    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        wb_sel_e            wb_sel;
        load_kind_e         load_kind;
        logic               wb_en;
        logic [1:0]         addr_offset;
        logic [`WORD_W-1:0] alu_result;
        logic [`WORD_W-1:0] pc_plus;
        logic [`WORD_W-1:0] mmio_data;
    } wb_stage_t;

    typedef struct packed {
        logic               en;
        logic [`REG_AW-1:0] addr;
        logic [`WORD_W-1:0] data;
    } wb_write_t;

endpackage : ex_wb_pkg

// ==== logic/ex_wb_stage.sv ====
`timescale 1ns/1ps
`include "ex_wb_defines.svh"

module ex_wb_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  ex_wb_pkg::ex_wb_t     ex_i,
    input  logic [`WORD_W-1:0]    mmio_rdata_i,
    output ex_wb_pkg::wb_stage_t  stage_o
);

    logic                    wb_en_q;
    logic [`REG_AW-1:0]      rd_q;
    ex_wb_pkg::wb_sel_e      wb_sel_q;
    ex_wb_pkg::load_kind_e   load_kind_q;
    logic [1:0]              addr_offset_q;
    logic [`WORD_W-1:0]      alu_result_q;
    logic [`WORD_W-1:0]      pc_plus_q;
    logic [`WORD_W-1:0]      mmio_data_q;

    // ####################
    // Control
    // ####################

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_en_q <= 1'b0;
        end else begin
            wb_en_q <= ex_i.wb_en;
        end
    end

    // ####################
    // Payload
    // ####################

    always_ff @(posedge clk) begin
        rd_q          <= ex_i.rd;
        wb_sel_q      <= ex_i.wb_sel;
        load_kind_q   <= ex_i.load_kind;
        addr_offset_q <= ex_i.alu_result[1:0];   // Enough for byte and halfword lanes
        alu_result_q  <= ex_i.alu_result;
        pc_plus_q     <= ex_i.pc_plus;
        mmio_data_q   <= mmio_rdata_i;           // Sampled with the instruction itself
    end

    always_comb begin
        stage_o.rd          = rd_q;
        stage_o.wb_sel      = wb_sel_q;
        stage_o.load_kind   = load_kind_q;
        stage_o.wb_en       = wb_en_q;
        stage_o.addr_offset = addr_offset_q;
        stage_o.alu_result  = alu_result_q;
        stage_o.pc_plus     = pc_plus_q;
        stage_o.mmio_data   = mmio_data_q;
    end

endmodule : ex_wb_stage

// ==== logic/mmio_regs.sv ====
`timescale 1ns/1ps
`include "ex_wb_defines.svh"

module mmio_regs (
    input  logic                clk,
    input  logic                arst_n_i,
    input  ex_wb_pkg::ex_wb_t   ex_i,
    input  logic                inst_exec_i,
    input  logic                rx_valid_i,
    input  logic [7:0]          rx_byte_i,
    input  logic                tx_ready_i,
    output logic [`WORD_W-1:0]  mmio_rdata_o,
    output logic                rx_pop_o,
    output logic                tx_push_o
);

    logic [`WORD_W-1:0] cycle_cnt;
    logic [`WORD_W-1:0] instret_cnt;
    logic               hit_stat;
    logic               hit_data;
    logic               hit_cycle;
    logic               hit_instret;
    logic               hit_cnt_rst;
    logic               cnt_clear;
    logic               is_mmio_load;

    // ####################
    // Address decode
    // ####################

    assign hit_stat    = (ex_i.alu_result == `MMIO_UART_STAT);
    assign hit_data    = (ex_i.alu_result == `MMIO_UART_DATA);
    assign hit_cycle   = (ex_i.alu_result == `MMIO_CYCLE);
    assign hit_instret = (ex_i.alu_result == `MMIO_INSTRET);
    assign hit_cnt_rst = (ex_i.alu_result == `MMIO_CNT_RST);

    assign is_mmio_load = !ex_i.store && (ex_i.wb_sel == ex_wb_pkg::WB_MMIO);

    assign cnt_clear = ex_i.store && hit_cnt_rst;
    assign rx_pop_o  = is_mmio_load && hit_data;   // Buffer empties on this edge
    assign tx_push_o = ex_i.store && hit_data;     // The link drops it when busy

    // ####################
    // Counters
    // ####################

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cycle_cnt   <= '0;
            instret_cnt <= '0;
        end else if (cnt_clear) begin
            // Clear wins over this edge's increment
            cycle_cnt   <= '0;
            instret_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (inst_exec_i) begin
                instret_cnt <= instret_cnt + 1'b1;
            end
        end
    end

    // ####################
    // Read data
    // ####################

    // Counters read as they stand before the edge that retires the load
    always_comb begin
        if (hit_stat) begin
            mmio_rdata_o = {{(`WORD_W-2){1'b0}}, rx_valid_i, tx_ready_i};
        end else if (hit_data) begin
            mmio_rdata_o = {{(`WORD_W-8){1'b0}}, rx_byte_i};
        end else if (hit_cycle) begin
            mmio_rdata_o = cycle_cnt;
        end else if (hit_instret) begin
            mmio_rdata_o = instret_cnt;
        end else begin
            mmio_rdata_o = '0;   // Unmapped and write-only addresses
        end
    end

endmodule : mmio_regs

// ==== logic/uart_link.sv ====
`timescale 1ns/1ps

module uart_link (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        uart_rx_req_i,
    input  logic [7:0]  uart_rx_data_i,
    output logic        uart_rx_ack_o,
    input  logic        uart_tx_ack_i,
    output logic        uart_tx_req_o,
    output logic [7:0]  uart_tx_data_o,
    input  logic        rx_pop_i,
    input  logic        tx_push_i,
    input  logic [7:0]  tx_byte_i,
    output logic        rx_valid_o,
    output logic [7:0]  rx_byte_o,
    output logic        tx_ready_o
);

    typedef enum logic [1:0] {RX_IDLE, RX_ACKED, RX_RELEASED} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_REQ, TX_WAIT_REL} tx_state_e;

    rx_state_e rx_state;
    tx_state_e tx_state;

    // ####################
    // Receive side
    // ####################

    // A full buffer keeps the FSM out of RX_IDLE's accept path, so ack stays low
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_state      <= RX_IDLE;
            uart_rx_ack_o <= 1'b0;
            rx_valid_o    <= 1'b0;
            rx_byte_o     <= '0;
        end else begin
            if (rx_pop_i) begin
                rx_valid_o <= 1'b0;
            end
            case (rx_state)
                RX_IDLE: if (uart_rx_req_i) begin
                    uart_rx_ack_o <= 1'b1;
                    rx_byte_o     <= uart_rx_data_i;   // Data is stable while req is high
                    rx_valid_o    <= 1'b1;
                    rx_state      <= RX_ACKED;
                end
                RX_ACKED: if (!uart_rx_req_i) begin
                    uart_rx_ack_o <= 1'b0;
                    rx_state      <= (rx_valid_o && !rx_pop_i) ? RX_RELEASED : RX_IDLE;
                end
                RX_RELEASED: if (rx_pop_i) begin
                    rx_state <= RX_IDLE;
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // ####################
    // Transmit side
    // ####################

    assign tx_ready_o = (tx_state == TX_IDLE);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_state       <= TX_IDLE;
            uart_tx_req_o  <= 1'b0;
            uart_tx_data_o <= '0;
        end else begin
            case (tx_state)
                TX_IDLE: if (tx_push_i) begin
                    uart_tx_data_o <= tx_byte_i;
                    uart_tx_req_o  <= 1'b1;
                    tx_state       <= TX_REQ;
                end
                TX_REQ: if (uart_tx_ack_i) begin
                    uart_tx_req_o <= 1'b0;
                    tx_state      <= TX_WAIT_REL;
                end
                TX_WAIT_REL: if (!uart_tx_ack_i) begin
                    tx_state <= TX_IDLE;
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

endmodule : uart_link

// ==== logic/wb_select.sv ====
`timescale 1ns/1ps
`include "ex_wb_defines.svh"

module wb_select (
    input  ex_wb_pkg::wb_stage_t  stage_i,
    input  logic [`WORD_W-1:0]    dmem_rdata_i,
    output ex_wb_pkg::wb_write_t  wb_o
);

    logic [7:0]         load_byte;
    logic [15:0]        load_half;
    logic [`WORD_W-1:0] load_value;

    // ####################
    // Load alignment
    // ####################

    always_comb begin
        case (stage_i.addr_offset)
            2'd0:    load_byte = dmem_rdata_i[7:0];
            2'd1:    load_byte = dmem_rdata_i[15:8];
            2'd2:    load_byte = dmem_rdata_i[23:16];
            default: load_byte = dmem_rdata_i[31:24];
        endcase
    end

    // Misaligned halfwords are not legal, bit 0 of the offset is ignored
    assign load_half = stage_i.addr_offset[1] ? dmem_rdata_i[31:16] : dmem_rdata_i[15:0];

    always_comb begin
        case (stage_i.load_kind)
            ex_wb_pkg::LD_B:  load_value = {{(`WORD_W-8){load_byte[7]}}, load_byte};
            ex_wb_pkg::LD_BU: load_value = {{(`WORD_W-8){1'b0}}, load_byte};
            ex_wb_pkg::LD_H:  load_value = {{(`WORD_W-16){load_half[15]}}, load_half};
            ex_wb_pkg::LD_HU: load_value = {{(`WORD_W-16){1'b0}}, load_half};
            default:          load_value = dmem_rdata_i;
        endcase
    end

    // ####################
    // Writeback mux
    // ####################

    always_comb begin
        case (stage_i.wb_sel)
            ex_wb_pkg::WB_LOAD: wb_o.data = load_value;
            ex_wb_pkg::WB_PC4:  wb_o.data = stage_i.pc_plus;
            ex_wb_pkg::WB_MMIO: wb_o.data = stage_i.mmio_data;
            default:            wb_o.data = stage_i.alu_result;
        endcase
    end

    assign wb_o.addr = stage_i.rd;
    assign wb_o.en   = stage_i.wb_en && (stage_i.rd != '0);   // x0 is never written

endmodule : wb_select

// ==== logic/ex_wb_top.sv ====
`timescale 1ns/1ps
`include "ex_wb_defines.svh"

module ex_wb_top (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  ex_wb_pkg::ex_wb_t     ex_i,
    input  logic                  inst_exec_i,
    input  logic [`WORD_W-1:0]    dmem_rdata_i,
    input  logic                  uart_rx_req_i,
    input  logic [7:0]            uart_rx_data_i,
    output logic                  uart_rx_ack_o,
    input  logic                  uart_tx_ack_i,
    output logic                  uart_tx_req_o,
    output logic [7:0]            uart_tx_data_o,
    output ex_wb_pkg::wb_write_t  wb_o
);

    ex_wb_pkg::wb_stage_t stage;
    logic [`WORD_W-1:0]   mmio_rdata;
    logic                 rx_pop;
    logic                 tx_push;
    logic                 rx_valid;
    logic [7:0]           rx_byte;
    logic                 tx_ready;

    ex_wb_stage u_ex_wb_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ex_i         (ex_i),
        .mmio_rdata_i (mmio_rdata),
        .stage_o      (stage)
    );

    mmio_regs u_mmio_regs (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ex_i         (ex_i),
        .inst_exec_i  (inst_exec_i),
        .rx_valid_i   (rx_valid),
        .rx_byte_i    (rx_byte),
        .tx_ready_i   (tx_ready),
        .mmio_rdata_o (mmio_rdata),
        .rx_pop_o     (rx_pop),
        .tx_push_o    (tx_push)
    );

    // The tx byte comes straight from execute, in step with the push
    uart_link u_uart_link (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .uart_rx_req_i  (uart_rx_req_i),
        .uart_rx_data_i (uart_rx_data_i),
        .uart_rx_ack_o  (uart_rx_ack_o),
        .uart_tx_ack_i  (uart_tx_ack_i),
        .uart_tx_req_o  (uart_tx_req_o),
        .uart_tx_data_o (uart_tx_data_o),
        .rx_pop_i       (rx_pop),
        .tx_push_i      (tx_push),
        .tx_byte_i      (ex_i.store_data),
        .rx_valid_o     (rx_valid),
        .rx_byte_o      (rx_byte),
        .tx_ready_o     (tx_ready)
    );

    wb_select u_wb_select (
        .stage_i      (stage),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_o         (wb_o)
    );

endmodule : ex_wb_top

// ==== dv/tb_ex_wb.sv ====
`timescale 1ns/1ps
`include "ex_wb_defines.svh"

module tb_ex_wb;

    typedef struct packed {
        ex_wb_pkg::ex_wb_t    ex;
        logic                 inst;
        logic [`WORD_W-1:0]   dmem;
        ex_wb_pkg::wb_write_t exp;
        logic                 rnd;   // rd and ALU data come from the LFSR
    } row_t;

    logic                 clk;
    logic                 arst_n_i;
    ex_wb_pkg::ex_wb_t    ex_i;
    logic                 inst_exec_i;
    logic [`WORD_W-1:0]   dmem_rdata_i;
    logic                 uart_rx_req_i;
    logic [7:0]           uart_rx_data_i;
    logic                 uart_rx_ack_o;
    logic                 uart_tx_ack_i;
    logic                 uart_tx_req_o;
    logic [7:0]           uart_tx_data_o;
    ex_wb_pkg::wb_write_t wb_o;

    row_t               rows[$];
    int                 seg_last[6];
    int                 err_value;
    int                 err_handshake;
    int                 tb_cycles;
    int                 cycle_limit;
    logic [31:0]        lfsr_state;
    logic [`WORD_W-1:0] ref_cycle;
    logic [`WORD_W-1:0] ref_instret;
    logic               ref_rx_valid;
    logic [7:0]         ref_rx_byte;
    logic               ref_tx_ready;
    logic               ref_tx_req;
    logic [7:0]         ref_tx_byte;

    ex_wb_top u_ex_wb_top (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .ex_i           (ex_i),
        .inst_exec_i    (inst_exec_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .uart_rx_req_i  (uart_rx_req_i),
        .uart_rx_data_i (uart_rx_data_i),
        .uart_rx_ack_o  (uart_rx_ack_o),
        .uart_tx_ack_i  (uart_tx_ack_i),
        .uart_tx_req_o  (uart_tx_req_o),
        .uart_tx_data_o (uart_tx_data_o),
        .wb_o           (wb_o)
    );

    always #10 clk = ~clk;

    // ####################
    // Reference model
    // ####################

    // The clear wins over the increment
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ref_cycle   <= '0;
            ref_instret <= '0;
        end else if (ex_i.store && (ex_i.alu_result == `MMIO_CNT_RST)) begin
            ref_cycle   <= '0;
            ref_instret <= '0;
        end else begin
            ref_cycle <= ref_cycle + 32'd1;
            if (inst_exec_i) begin
                ref_instret <= ref_instret + 32'd1;
            end
        end
    end

    always @(posedge clk) begin
        tb_cycles <= tb_cycles + 1;
        if (tb_cycles >= cycle_limit) begin
            $display("Run stopped at cycle %0d before the test sequence ended", tb_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        case (addr)
            `MMIO_UART_STAT: return {30'd0, ref_rx_valid, ref_tx_ready};
            `MMIO_UART_DATA: return {24'd0, ref_rx_byte};
            `MMIO_CYCLE:     return ref_cycle;
            `MMIO_INSTRET:   return ref_instret;
            default:         return 32'd0;
        endcase
    endfunction

    // Called on the edge that moves the row into writeback
    task automatic resolve_expect(input row_t r, output ex_wb_pkg::wb_write_t exp);
        exp = r.exp;
        if (!r.ex.store && (r.ex.wb_sel == ex_wb_pkg::WB_MMIO)) begin
            exp.data = model_read(r.ex.alu_result);
            if (r.ex.alu_result == `MMIO_UART_DATA) begin
                ref_rx_valid = 1'b0;
            end
        end
        if (r.ex.store && (r.ex.alu_result == `MMIO_UART_DATA) && ref_tx_ready) begin
            ref_tx_ready = 1'b0;
            ref_tx_req   = 1'b1;
            ref_tx_byte  = r.ex.store_data;
        end
    endtask

    // ####################
    // Checks
    // ####################

    task automatic check_wb(input ex_wb_pkg::wb_write_t exp, input ex_wb_pkg::wb_write_t act);
        if (act.en !== exp.en) begin
            $display("[FAIL] %0t wb_o.en expected %0b got %0b", $time, exp.en, act.en);
            err_value++;
        end else if (exp.en && ((act.addr !== exp.addr) || (act.data !== exp.data))) begin
            $display("[FAIL] %0t wb_o expected rd %0d data %h got rd %0d data %h",
                     $time, exp.addr, exp.data, act.addr, act.data);
            err_value++;
        end
    endtask

    task automatic check_link(input string name, input logic exp_hs, input logic act_hs,
                              input logic [7:0] exp_byte, input logic [7:0] act_byte);
        if ((act_hs !== exp_hs) || (act_byte !== exp_byte)) begin
            $display("[FAIL] %0t %s_req_o expected %0b got %0b, %s_data_o expected %h got %h",
                     $time, name, exp_hs, act_hs, name, exp_byte, act_byte);
            err_value++;
        end
    endtask

    task automatic check_ack(input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t uart_rx_ack_o expected %0b got %0b", $time, exp, act);
            err_value++;
        end
    endtask

    task automatic wait_handshake(input logic tx_side, input logic level);
        logic seen;
        seen = 1'b0;
        for (int n = 0; (n < 16) && !seen; n++) begin
            @(negedge clk);
            seen = ((tx_side ? uart_tx_req_o : uart_rx_ack_o) === level);
        end
        if (!seen) begin
            $display("Handshake did not complete, %s never went to %0b",
                     tx_side ? "uart_tx_req_o" : "uart_rx_ack_o", level);
            err_handshake++;
        end
    endtask

    // ####################
    // Stimulus table
    // ####################

    function automatic ex_wb_pkg::ex_wb_t make_ex(input logic [31:0] alu, input logic [4:0] rd,
                                                  input ex_wb_pkg::wb_sel_e sel,
                                                  input ex_wb_pkg::load_kind_e kind,
                                                  input logic wb_en, input logic store,
                                                  input logic [7:0] sdata);
        ex_wb_pkg::ex_wb_t ex;
        ex.alu_result = alu;
        ex.rd         = rd;
        ex.wb_sel     = sel;
        ex.load_kind  = kind;
        ex.wb_en      = wb_en;
        ex.store      = store;
        ex.store_data = sdata;
        ex.pc_plus    = 32'h0000_2004;
        return ex;
    endfunction

    task automatic add_row(input ex_wb_pkg::ex_wb_t ex, input logic inst, input logic [31:0] dmem,
                           input logic [31:0] exp_data, input logic rnd);
        row_t r;
        r.ex       = ex;
        r.inst     = inst;
        r.dmem     = dmem;
        r.rnd      = rnd;
        r.exp.en   = ex.wb_en && (ex.rd != 5'd0);   // x0 suppression
        r.exp.addr = ex.rd;
        r.exp.data = exp_data;
        rows.push_back(r);
    endtask

    task automatic alu_row(input logic [4:0] rd, input logic [31:0] data, input logic inst);
        add_row(make_ex(data, rd, ex_wb_pkg::WB_ALU, ex_wb_pkg::LD_W, 1'b1, 1'b0, 8'h00),
                inst, 32'h0bad_f00d, data, 1'b0);
    endtask

    task automatic load_row(input logic [4:0] rd, input logic [31:0] addr,
                            input ex_wb_pkg::load_kind_e kind, input logic [31:0] dmem,
                            input logic [31:0] exp_data);
        add_row(make_ex(addr, rd, ex_wb_pkg::WB_LOAD, kind, 1'b1, 1'b0, 8'h00),
                1'b1, dmem, exp_data, 1'b0);
    endtask

    task automatic mmio_row(input logic [31:0] addr, input logic [4:0] rd);
        add_row(make_ex(addr, rd, ex_wb_pkg::WB_MMIO, ex_wb_pkg::LD_W, 1'b1, 1'b0, 8'h00),
                1'b1, 32'h0bad_f00d, 32'h0, 1'b0);   // Data comes from the model
    endtask

    task automatic store_row(input logic [31:0] addr, input logic [7:0] sdata);
        add_row(make_ex(addr, 5'd0, ex_wb_pkg::WB_ALU, ex_wb_pkg::LD_W, 1'b0, 1'b1, sdata),
                1'b1, 32'h0bad_f00d, 32'h0, 1'b0);
    endtask

    task automatic fill_table();
        ex_wb_pkg::ex_wb_t ex;
        mmio_row(`MMIO_UART_STAT, 5'd1);
        alu_row(5'd5, 32'h1234_5678, 1'b1);
        alu_row(5'd0, 32'hffff_ffff, 1'b1);
        ex = make_ex(32'h0000_0040, 5'd1, ex_wb_pkg::WB_PC4, ex_wb_pkg::LD_W, 1'b1, 1'b0, 8'h00);
        ex.pc_plus = 32'h0000_0abc;
        add_row(ex, 1'b1, 32'h0bad_f00d, 32'h0000_0abc, 1'b0);
        repeat (3) begin
            add_row(make_ex(32'h0, 5'd0, ex_wb_pkg::WB_ALU, ex_wb_pkg::LD_W, 1'b1, 1'b0, 8'h00),
                    1'b1, 32'h0bad_f00d, 32'h0, 1'b1);
        end
        load_row(5'd13, 32'h0000_1000, ex_wb_pkg::LD_B,  32'h8a7b_c6d5, 32'hffff_ffd5);
        load_row(5'd14, 32'h0000_1003, ex_wb_pkg::LD_B,  32'h8a7b_c6d5, 32'hffff_ff8a);
        load_row(5'd15, 32'h0000_1001, ex_wb_pkg::LD_BU, 32'h8a7b_c6d5, 32'h0000_00c6);
        load_row(5'd16, 32'h0000_1002, ex_wb_pkg::LD_BU, 32'h8a7b_c6d5, 32'h0000_007b);
        load_row(5'd2,  32'h0000_1001, ex_wb_pkg::LD_B,  32'h8a7b_c6d5, 32'hffff_ffc6);
        load_row(5'd3,  32'h0000_1002, ex_wb_pkg::LD_B,  32'h8a7b_c6d5, 32'h0000_007b);
        load_row(5'd4,  32'h0000_1000, ex_wb_pkg::LD_BU, 32'h8a7b_c6d5, 32'h0000_00d5);
        load_row(5'd6,  32'h0000_1003, ex_wb_pkg::LD_BU, 32'h8a7b_c6d5, 32'h0000_008a);
        load_row(5'd17, 32'h0000_1000, ex_wb_pkg::LD_H,  32'h8a7b_c6d5, 32'hffff_c6d5);
        load_row(5'd18, 32'h0000_1002, ex_wb_pkg::LD_H,  32'h1234_5678, 32'h0000_1234);
        load_row(5'd19, 32'h0000_1002, ex_wb_pkg::LD_HU, 32'h8a7b_c6d5, 32'h0000_8a7b);
        load_row(5'd20, 32'h0000_1000, ex_wb_pkg::LD_HU, 32'h8a7b_c6d5, 32'h0000_c6d5);
        load_row(5'd21, 32'h0000_1000, ex_wb_pkg::LD_W,  32'h8a7b_c6d5, 32'h8a7b_c6d5);
        store_row(`MMIO_CNT_RST, 8'h00);
        alu_row(5'd7, 32'h0000_0007, 1'b1);
        alu_row(5'd8, 32'h0000_0008, 1'b0);
        alu_row(5'd9, 32'h0000_0009, 1'b1);
        mmio_row(`MMIO_CYCLE, 5'd10);        // Four rows after the clear
        mmio_row(`MMIO_INSTRET, 5'd11);
        mmio_row(32'h8000_0020, 5'd12);
        seg_last[0] = rows.size() - 1;
        mmio_row(`MMIO_UART_STAT, 5'd22);
        mmio_row(`MMIO_UART_DATA, 5'd23);
        mmio_row(`MMIO_UART_STAT, 5'd24);
        seg_last[1] = rows.size() - 1;
        mmio_row(`MMIO_UART_DATA, 5'd25);
        seg_last[2] = rows.size() - 1;
        mmio_row(`MMIO_UART_DATA, 5'd26);
        mmio_row(`MMIO_UART_STAT, 5'd27);
        seg_last[3] = rows.size() - 1;
        store_row(`MMIO_UART_DATA, 8'ha5);
        mmio_row(`MMIO_UART_STAT, 5'd28);
        store_row(`MMIO_UART_DATA, 8'h11);  // Dropped while the link is busy
        mmio_row(`MMIO_UART_STAT, 5'd29);
        seg_last[4] = rows.size() - 1;
        mmio_row(`MMIO_UART_STAT, 5'd30);
        seg_last[5] = rows.size() - 1;
    endtask

    // ####################
    // Sequencing
    // ####################

    // A row enters execute on one edge and is checked after the next one
    task automatic run_rows(input int first, input int last);
        row_t                 cur;
        row_t                 prev;
        ex_wb_pkg::wb_write_t exp_prev;
        logic [31:0]          rnd_val;
        for (int i = first; i <= last + 1; i++) begin
            @(posedge clk);
            if (i > first) begin
                resolve_expect(prev, exp_prev);
                dmem_rdata_i <= prev.dmem;   // Memory word arrives in writeback
            end
            if (i <= last) begin
                cur = rows[i];
                if (cur.rnd) begin
                    take_bits(5, rnd_val);
                    cur.ex.rd = rnd_val[4:0];
                    take_bits(32, rnd_val);
                    cur.ex.alu_result = rnd_val;
                    cur.exp = {(cur.ex.rd != 5'd0), cur.ex.rd, rnd_val};
                end
                ex_i        <= cur.ex;
                inst_exec_i <= cur.inst;
                prev = cur;
            end else begin
                ex_i        <= make_ex(32'h0, 5'd0, ex_wb_pkg::WB_ALU, ex_wb_pkg::LD_W,
                                       1'b0, 1'b0, 8'h00);
                inst_exec_i <= 1'b0;
            end
            @(negedge clk);
            if (i > first) begin
                check_wb(exp_prev, wb_o);
                check_link("uart_tx", ref_tx_req, uart_tx_req_o, ref_tx_byte, uart_tx_data_o);
            end
        end
    endtask

    task automatic raise_rx_req(input logic [7:0] b);
        @(posedge clk);
        uart_rx_req_i  <= 1'b1;
        uart_rx_data_i <= b;
    endtask

    task automatic finish_rx(input logic [7:0] b);
        wait_handshake(1'b0, 1'b1);
        ref_rx_valid = 1'b1;
        ref_rx_byte  = b;
        @(posedge clk);
        uart_rx_req_i <= 1'b0;
        wait_handshake(1'b0, 1'b0);
    endtask

    task automatic complete_tx();
        @(posedge clk);
        uart_tx_ack_i <= 1'b1;
        wait_handshake(1'b1, 1'b0);
        ref_tx_req = 1'b0;
        @(posedge clk);
        uart_tx_ack_i <= 1'b0;
        @(posedge clk);
        ref_tx_ready = 1'b1;   // Idle once ack is seen low
        @(negedge clk);
        check_link("uart_tx", ref_tx_req, uart_tx_req_o, ref_tx_byte, uart_tx_data_o);
    endtask

    initial begin
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        ex_i           = make_ex(32'h0, 5'd0, ex_wb_pkg::WB_ALU, ex_wb_pkg::LD_W, 1'b0, 1'b0, 8'h00);
        inst_exec_i    = 1'b0;
        dmem_rdata_i   = '0;
        uart_rx_req_i  = 1'b0;
        uart_rx_data_i = '0;
        uart_tx_ack_i  = 1'b0;
        err_value      = 0;
        err_handshake  = 0;
        tb_cycles      = 0;
        lfsr_state     = 32'h6e36_0dc6;
        ref_rx_valid   = 1'b0;
        ref_rx_byte    = '0;
        ref_tx_ready   = 1'b1;
        ref_tx_req     = 1'b0;
        ref_tx_byte    = '0;
        fill_table();
        cycle_limit = 4 * rows.size() + 200;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_wb('0, wb_o);
        check_ack(1'b0, uart_rx_ack_o);
        check_link("uart_tx", 1'b0, uart_tx_req_o, 8'h00, uart_tx_data_o);
        run_rows(0, seg_last[0]);
        raise_rx_req(8'h5a);
        finish_rx(8'h5a);
        run_rows(seg_last[0] + 1, seg_last[1]);
        raise_rx_req(8'hc3);
        finish_rx(8'hc3);
        raise_rx_req(8'h3c);
        repeat (4) begin
            @(negedge clk);
            check_ack(1'b0, uart_rx_ack_o);   // Buffer still full
        end
        run_rows(seg_last[1] + 1, seg_last[2]);
        finish_rx(8'h3c);
        run_rows(seg_last[2] + 1, seg_last[3]);
        run_rows(seg_last[3] + 1, seg_last[4]);
        complete_tx();
        run_rows(seg_last[4] + 1, seg_last[5]);
        $display("Errors: %0d wrong values, %0d stalled handshakes", err_value, err_handshake);
        if ((err_value == 0) && (err_handshake == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_ex_wb

// ==== flist.f ====
+incdir+logic
logic/ex_wb_pkg.sv
logic/ex_wb_stage.sv
logic/mmio_regs.sv
logic/uart_link.sv
logic/wb_select.sv
logic/ex_wb_top.sv
dv/tb_ex_wb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_ex_wb -o tb_ex_wb
./obj_dir/tb_ex_wb | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
